// File: logic/ntt_bank_pkg.sv
package ntt_bank_pkg;

   localparam int NUM_BANKS   = 8;
   localparam int COEFF_WIDTH = 12;
   localparam int ADDR_WIDTH  = 5;

   typedef logic [COEFF_WIDTH-1:0] coeff_t;
   typedef logic [ADDR_WIDTH-1:0]  bank_addr_t;
   typedef logic [NUM_BANKS-1:0]   bank_mask_t;

   // Field k belongs to lane k on input, bank k on output
   typedef struct packed {
      bank_addr_t [NUM_BANKS-1:0] port_a;
      bank_addr_t [NUM_BANKS-1:0] port_b;
   } pair_addr_t;

   typedef struct packed {
      coeff_t [NUM_BANKS-1:0] port_a;
      coeff_t [NUM_BANKS-1:0] port_b;
   } pair_data_t;

   // Lengths 2 to 16 share the direct routing
   typedef enum logic [1:0] {
      MODE_DIRECT = 2'd0,
      MODE_LEN32  = 2'd1,
      MODE_LEN64  = 2'd2,
      MODE_LEN128 = 2'd3
   } chain_mode_t;

endpackage

// File: logic/dual_port_ram.sv
`timescale 1ns/100ps

module dual_port_ram import ntt_bank_pkg::*; (
   input  logic       clk_i,
   input  logic       we_i,
   input  bank_addr_t raddr_a_i,
   input  bank_addr_t raddr_b_i,
   input  bank_addr_t waddr_a_i,
   input  bank_addr_t waddr_b_i,
   input  coeff_t     din_a_i,
   input  coeff_t     din_b_i,
   output coeff_t     dout_a_o,
   output coeff_t     dout_b_o
);

   coeff_t mem [2**ADDR_WIDTH];

   // Port B written last so it wins on an address clash
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_a_i] <= din_a_i;
         mem[waddr_b_i] <= din_b_i;
      end
   end

   // Registered reads, old data on a same-cycle write
   always_ff @(posedge clk_i) begin
      dout_a_o <= mem[raddr_a_i];
      dout_b_o <= mem[raddr_b_i];
   end

endmodule

// File: logic/read_addr_router.sv
`timescale 1ns/100ps

module read_addr_router import ntt_bank_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        load_i,
   input  logic        exec_i,
   input  chain_mode_t mode_i,
   input  bank_addr_t  load_addr_a_i,
   input  bank_addr_t  load_addr_b_i,
   input  pair_addr_t  lane_addr_i,
   output pair_addr_t  raddr_o
);

   pair_addr_t perm_addr;

   // Lane to bank permutation for the current chain mode
   always_comb begin
      perm_addr = lane_addr_i;
      for (int k = 0; k < NUM_BANKS; k++) begin
         case (mode_i)
            MODE_LEN32: begin
               // Neighbouring banks split one butterfly group
               if (k % 2 == 0) begin
                  perm_addr.port_a[k] = lane_addr_i.port_a[k];
                  perm_addr.port_b[k] = lane_addr_i.port_a[k ^ 1];
               end else begin
                  perm_addr.port_a[k] = lane_addr_i.port_b[k ^ 1];
                  perm_addr.port_b[k] = lane_addr_i.port_b[k];
               end
            end
            MODE_LEN64: begin
               // Groups of four banks, a lanes then b lanes
               if (k % 4 < 2) begin
                  perm_addr.port_a[k] = lane_addr_i.port_a[(k / 4) * 4 + (k % 2) * 2];
                  perm_addr.port_b[k] = lane_addr_i.port_a[(k / 4) * 4 + (k % 2) * 2 + 1];
               end else begin
                  perm_addr.port_a[k] = lane_addr_i.port_b[(k / 4) * 4 + (k % 2) * 2];
                  perm_addr.port_b[k] = lane_addr_i.port_b[(k / 4) * 4 + (k % 2) * 2 + 1];
               end
            end
            MODE_LEN128: begin
               // Lower banks take a lanes, upper banks b lanes
               if (k < NUM_BANKS / 2) begin
                  perm_addr.port_a[k] = lane_addr_i.port_a[(k % 4) * 2];
                  perm_addr.port_b[k] = lane_addr_i.port_a[(k % 4) * 2 + 1];
               end else begin
                  perm_addr.port_a[k] = lane_addr_i.port_b[(k % 4) * 2];
                  perm_addr.port_b[k] = lane_addr_i.port_b[(k % 4) * 2 + 1];
               end
            end
            default: begin
               perm_addr.port_a[k] = lane_addr_i.port_a[k];
               perm_addr.port_b[k] = lane_addr_i.port_b[k];
            end
         endcase
      end
   end

   // Load wins over exec
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         raddr_o <= '0;
      end else if (load_i) begin
         raddr_o.port_a <= {NUM_BANKS{load_addr_a_i}};
         raddr_o.port_b <= {NUM_BANKS{load_addr_b_i}};
      end else if (exec_i) begin
         raddr_o <= perm_addr;
      end
   end

endmodule

// File: logic/writeback_addr_delay.sv
`timescale 1ns/100ps

module writeback_addr_delay import ntt_bank_pkg::*; #(
   parameter int DELAY_STAGES = 7
) (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       exec_i,
   input  pair_addr_t lane_addr_i,
   output pair_addr_t delayed_addr_o
);

   pair_addr_t stage_q [DELAY_STAGES];

   // Advances once per exec, stage 0 holds the newest
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         for (int i = 0; i < DELAY_STAGES; i++) begin
            stage_q[i] <= '0;
         end
      end else if (exec_i) begin
         stage_q[0] <= lane_addr_i;
         for (int i = 1; i < DELAY_STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign delayed_addr_o = stage_q[DELAY_STAGES-1];

endmodule

// File: logic/write_port_ctrl.sv
`timescale 1ns/100ps

module write_port_ctrl import ntt_bank_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       load_i,
   input  logic       write_i,
   input  bank_mask_t mask_i,
   input  bank_addr_t load_addr_a_i,
   input  bank_addr_t load_addr_b_i,
   input  coeff_t     load_data_a_i,
   input  coeff_t     load_data_b_i,
   input  pair_addr_t delayed_addr_i,
   input  pair_data_t wb_data_i,
   output pair_addr_t waddr_o,
   output pair_data_t wdata_o,
   output bank_mask_t we_o
);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         waddr_o <= '0;
         wdata_o <= '0;
         we_o    <= '0;
      end else if (load_i) begin
         // Same pair to every bank, mask picks the targets
         waddr_o.port_a <= {NUM_BANKS{load_addr_a_i}};
         waddr_o.port_b <= {NUM_BANKS{load_addr_b_i}};
         wdata_o.port_a <= {NUM_BANKS{load_data_a_i}};
         wdata_o.port_b <= {NUM_BANKS{load_data_b_i}};
         we_o           <= mask_i;
      end else if (write_i) begin
         // Write-back goes to the oldest held lane addresses
         waddr_o <= delayed_addr_i;
         wdata_o <= wb_data_i;
         we_o    <= mask_i;
      end else begin
         we_o <= '0;
      end
   end

endmodule

// File: logic/ntt_bank_top.sv
`timescale 1ns/100ps

module ntt_bank_top import ntt_bank_pkg::*; #(
   parameter int DELAY_STAGES = 7
) (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        load_i,
   input  logic        exec_i,
   input  logic        write_i,
   input  bank_mask_t  mask_i,
   input  bank_addr_t  load_addr_a_i,
   input  bank_addr_t  load_addr_b_i,
   input  coeff_t      load_data_a_i,
   input  coeff_t      load_data_b_i,
   input  chain_mode_t mode_i,
   input  pair_addr_t  lane_addr_i,
   input  pair_data_t  wb_data_i,
   output pair_data_t  rd_data_o
);

   pair_addr_t raddr;
   pair_addr_t delayed_addr;
   pair_addr_t waddr;
   pair_data_t wdata;
   bank_mask_t we;

   read_addr_router u_read_addr_router (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .load_i        (load_i),
      .exec_i        (exec_i),
      .mode_i        (mode_i),
      .load_addr_a_i (load_addr_a_i),
      .load_addr_b_i (load_addr_b_i),
      .lane_addr_i   (lane_addr_i),
      .raddr_o       (raddr)
   );

   writeback_addr_delay #(
      .DELAY_STAGES (DELAY_STAGES)
   ) u_writeback_addr_delay (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .exec_i         (exec_i),
      .lane_addr_i    (lane_addr_i),
      .delayed_addr_o (delayed_addr)
   );

   write_port_ctrl u_write_port_ctrl (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .load_i         (load_i),
      .write_i        (write_i),
      .mask_i         (mask_i),
      .load_addr_a_i  (load_addr_a_i),
      .load_addr_b_i  (load_addr_b_i),
      .load_data_a_i  (load_data_a_i),
      .load_data_b_i  (load_data_b_i),
      .delayed_addr_i (delayed_addr),
      .wb_data_i      (wb_data_i),
      .waddr_o        (waddr),
      .wdata_o        (wdata),
      .we_o           (we)
   );

   // Bank k takes field k of each bus
   for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
      dual_port_ram u_bank (
         .clk_i     (clk_i),
         .we_i      (we[k]),
         .raddr_a_i (raddr.port_a[k]),
         .raddr_b_i (raddr.port_b[k]),
         .waddr_a_i (waddr.port_a[k]),
         .waddr_b_i (waddr.port_b[k]),
         .din_a_i   (wdata.port_a[k]),
         .din_b_i   (wdata.port_b[k]),
         .dout_a_o  (rd_data_o.port_a[k]),
         .dout_b_o  (rd_data_o.port_b[k])
      );
   end

endmodule

// File: include/tb_ntt_bank_vectors.svh
`ifndef TB_NTT_BANK_VECTORS_SVH
`define TB_NTT_BANK_VECTORS_SVH

// Columns: operation, bank mask, chain mode, base address, lane address step
// Lane k uses base + step * 2k on side a and base + step * (2k + 1) on side b

typedef enum logic [2:0] {
   OP_FILL,
   OP_SWEEP,
   OP_LOAD,
   OP_SPOT,
   OP_EXEC,
   OP_WRITE,
   OP_RESET
} op_t;

typedef struct packed {
   op_t         op;
   bank_mask_t  mask;
   chain_mode_t mode;
   bank_addr_t  base;
   bank_addr_t  step;
} row_t;

localparam int NUM_ROWS = 24;

row_t vectors [NUM_ROWS] = '{
   '{OP_FILL,  8'hff, MODE_DIRECT, 5'd0,  5'd0},
   '{OP_SWEEP, 8'h00, MODE_DIRECT, 5'd0,  5'd0},
   '{OP_LOAD,  8'h55, MODE_DIRECT, 5'd5,  5'd0},
   '{OP_SPOT,  8'h00, MODE_DIRECT, 5'd5,  5'd0},
   '{OP_SPOT,  8'h00, MODE_DIRECT, 5'd6,  5'd0},
   '{OP_LOAD,  8'haa, MODE_DIRECT, 5'd20, 5'd0},
   '{OP_EXEC,  8'h00, MODE_DIRECT, 5'd18, 5'd1},
   '{OP_EXEC,  8'h00, MODE_DIRECT, 5'd3,  5'd1},
   // Target of the first write-back, seven strobes before it
   '{OP_EXEC,  8'h00, MODE_DIRECT, 5'd11, 5'd1},
   '{OP_EXEC,  8'h00, MODE_LEN32,  5'd0,  5'd1},
   '{OP_EXEC,  8'h00, MODE_LEN32,  5'd9,  5'd3},
   '{OP_EXEC,  8'h00, MODE_LEN64,  5'd4,  5'd1},
   '{OP_EXEC,  8'h00, MODE_LEN64,  5'd17, 5'd5},
   '{OP_EXEC,  8'h00, MODE_LEN128, 5'd8,  5'd1},
   '{OP_EXEC,  8'h00, MODE_LEN128, 5'd2,  5'd7},
   '{OP_WRITE, 8'hff, MODE_DIRECT, 5'd0,  5'd0},
   '{OP_EXEC,  8'h00, MODE_DIRECT, 5'd11, 5'd1},
   '{OP_WRITE, 8'h0f, MODE_DIRECT, 5'd0,  5'd0},
   '{OP_RESET, 8'h00, MODE_DIRECT, 5'd0,  5'd0},
   '{OP_EXEC,  8'h00, MODE_DIRECT, 5'd11, 5'd1},
   '{OP_SPOT,  8'h00, MODE_DIRECT, 5'd5,  5'd0},
   // Delay line was cleared, so this one lands at address 0
   '{OP_WRITE, 8'hff, MODE_DIRECT, 5'd0,  5'd0},
   '{OP_EXEC,  8'h00, MODE_DIRECT, 5'd0,  5'd0},
   '{OP_SPOT,  8'h00, MODE_DIRECT, 5'd0,  5'd0}
};

`endif

// File: testbench/tb_ntt_bank.sv
`timescale 1ns/100ps

module tb_ntt_bank import ntt_bank_pkg::*; ();

   localparam int DELAY_STAGES = 7;
   localparam int DEPTH        = 2**ADDR_WIDTH;
   localparam int RESET_CYCLES = 3;
   localparam int READ_LATENCY = 2;

   // Lane codes per bank, 0 to 7 are a lanes and 8 to 15 are b lanes
   localparam int LEN32_A  [NUM_BANKS] = '{0, 8, 2, 10, 4, 12, 6, 14};
   localparam int LEN32_B  [NUM_BANKS] = '{1, 9, 3, 11, 5, 13, 7, 15};
   localparam int LEN64_A  [NUM_BANKS] = '{0, 2, 8, 10, 4, 6, 12, 14};
   localparam int LEN64_B  [NUM_BANKS] = '{1, 3, 9, 11, 5, 7, 13, 15};
   localparam int LEN128_A [NUM_BANKS] = '{0, 2, 4, 6, 8, 10, 12, 14};
   localparam int LEN128_B [NUM_BANKS] = '{1, 3, 5, 7, 9, 11, 13, 15};

   `include "tb_ntt_bank_vectors.svh"

   logic        clk;
   logic        rst;
   logic        load_en;
   logic        exec_en;
   logic        write_en;
   bank_mask_t  mask;
   bank_addr_t  load_addr_a;
   bank_addr_t  load_addr_b;
   coeff_t      load_data_a;
   coeff_t      load_data_b;
   chain_mode_t mode;
   pair_addr_t  lane_addr;
   pair_data_t  wb_data;
   pair_data_t  rd_data;

   coeff_t     ref_mem [NUM_BANKS][DEPTH];
   pair_addr_t exec_hist [$];
   int         errors;
   integer     seed = 32'h346f;

   ntt_bank_top #(
      .DELAY_STAGES (DELAY_STAGES)
   ) u_dut (
      .clk_i         (clk),
      .rst_i         (rst),
      .load_i        (load_en),
      .exec_i        (exec_en),
      .write_i       (write_en),
      .mask_i        (mask),
      .load_addr_a_i (load_addr_a),
      .load_addr_b_i (load_addr_b),
      .load_data_a_i (load_data_a),
      .load_data_b_i (load_data_b),
      .mode_i        (mode),
      .lane_addr_i   (lane_addr),
      .wb_data_i     (wb_data),
      .rd_data_o     (rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic string op_label(op_t op);
      case (op)
         OP_FILL:  return "fill";
         OP_SWEEP: return "sweep";
         OP_LOAD:  return "masked load";
         OP_SPOT:  return "spot read";
         OP_EXEC:  return "exec";
         OP_WRITE: return "write-back";
         default:  return "reset";
      endcase
   endfunction

   function automatic int lane_code(chain_mode_t m, int k, bit port_b);
      case (m)
         MODE_LEN32:  return port_b ? LEN32_B[k] : LEN32_A[k];
         MODE_LEN64:  return port_b ? LEN64_B[k] : LEN64_A[k];
         MODE_LEN128: return port_b ? LEN128_B[k] : LEN128_A[k];
         default:     return port_b ? k + NUM_BANKS : k;
      endcase
   endfunction

   function automatic bank_addr_t lane_sel(pair_addr_t lanes, int code);
      if (code < NUM_BANKS) begin
         return lanes.port_a[code];
      end
      return lanes.port_b[code - NUM_BANKS];
   endfunction

   function automatic pair_addr_t make_lanes(bank_addr_t base, bank_addr_t step);
      pair_addr_t lanes;
      for (int k = 0; k < NUM_BANKS; k++) begin
         lanes.port_a[k] = bank_addr_t'(base + step * (2 * k));
         lanes.port_b[k] = bank_addr_t'(base + step * (2 * k + 1));
      end
      return lanes;
   endfunction

   function automatic pair_data_t predict_read(chain_mode_t m, pair_addr_t lanes);
      pair_data_t exp;
      for (int k = 0; k < NUM_BANKS; k++) begin
         exp.port_a[k] = ref_mem[k][lane_sel(lanes, lane_code(m, k, 1'b0))];
         exp.port_b[k] = ref_mem[k][lane_sel(lanes, lane_code(m, k, 1'b1))];
      end
      return exp;
   endfunction

   // Lane addresses of the seventh most recent exec, zero until that many
   function automatic pair_addr_t delayed_lanes();
      if (exec_hist.size() >= DELAY_STAGES) begin
         return exec_hist[DELAY_STAGES-1];
      end
      return '0;
   endfunction

   task automatic store_pair(input bank_mask_t m, input pair_addr_t addr,
                             input pair_data_t data);
      for (int k = 0; k < NUM_BANKS; k++) begin
         if (m[k]) begin
            ref_mem[k][addr.port_a[k]] = data.port_a[k];
            // B last, it wins a clash
            ref_mem[k][addr.port_b[k]] = data.port_b[k];
         end
      end
   endtask

   task automatic check_pair(input string name, input pair_data_t exp, input pair_data_t act);
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_coeff(input string name, input coeff_t exp, input coeff_t act);
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic apply_load(input bank_mask_t m, input bank_addr_t a, input bank_addr_t b,
                             input coeff_t da, input coeff_t db);
      pair_addr_t addr;
      pair_data_t data;
      for (int k = 0; k < NUM_BANKS; k++) begin
         addr.port_a[k] = a;
         addr.port_b[k] = b;
         data.port_a[k] = da;
         data.port_b[k] = db;
      end
      load_en     = 1'b1;
      mask        = m;
      load_addr_a = a;
      load_addr_b = b;
      load_data_a = da;
      load_data_b = db;
      @(negedge clk);
      load_en = 1'b0;
      mask    = '0;
      store_pair(m, addr, data);
   endtask

   task automatic apply_exec(input chain_mode_t m, input pair_addr_t lanes,
                             output pair_data_t exp);
      exp       = predict_read(m, lanes);
      exec_en   = 1'b1;
      mode      = m;
      lane_addr = lanes;
      exec_hist.push_front(lanes);
      if (exec_hist.size() > DELAY_STAGES) begin
         void'(exec_hist.pop_back());
      end
      @(negedge clk);
      exec_en = 1'b0;
      // Address edge, then the registered bank read
      repeat (READ_LATENCY - 1) @(negedge clk);
   endtask

   task automatic apply_write(input bank_mask_t m);
      pair_data_t wb;
      pair_addr_t addr;
      for (int k = 0; k < NUM_BANKS; k++) begin
         wb.port_a[k] = coeff_t'($random(seed));
         wb.port_b[k] = coeff_t'($random(seed));
      end
      addr     = delayed_lanes();
      write_en = 1'b1;
      mask     = m;
      wb_data  = wb;
      @(negedge clk);
      write_en = 1'b0;
      mask     = '0;
      store_pair(m, addr, wb);
   endtask

   task automatic pulse_reset();
      // Let a pending bank write land first
      @(negedge clk);
      rst = 1'b1;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      exec_hist.delete();
   endtask

   initial begin
      row_t       row;
      pair_data_t exp;
      string      name;

      errors      = 0;
      rst         = 1'b1;
      load_en     = 1'b0;
      exec_en     = 1'b0;
      write_en    = 1'b0;
      mask        = '0;
      load_addr_a = '0;
      load_addr_b = '0;
      load_data_a = '0;
      load_data_b = '0;
      mode        = MODE_DIRECT;
      lane_addr   = '0;
      wb_data     = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < NUM_ROWS; i++) begin
         row  = vectors[i];
         name = $sformatf("%s row %0d", op_label(row.op), i);
         case (row.op)
            OP_FILL: begin
               for (int j = 0; j < DEPTH; j++) begin
                  apply_load(row.mask, bank_addr_t'(j), bank_addr_t'(j + 1),
                             coeff_t'($random(seed)), coeff_t'($random(seed)));
               end
            end
            OP_SWEEP: begin
               for (int j = 0; j < DEPTH; j++) begin
                  apply_exec(MODE_DIRECT, make_lanes(bank_addr_t'(j), '0), exp);
                  check_pair($sformatf("%s addr %0d", name, j), exp, rd_data);
               end
            end
            OP_LOAD: begin
               apply_load(row.mask, row.base, bank_addr_t'(row.base + 1),
                          coeff_t'($random(seed)), coeff_t'($random(seed)));
            end
            OP_SPOT: begin
               apply_exec(MODE_DIRECT, make_lanes(row.base, '0), exp);
               for (int k = 0; k < NUM_BANKS; k++) begin
                  check_coeff($sformatf("%s bank %0d a", name, k),
                              exp.port_a[k], rd_data.port_a[k]);
                  check_coeff($sformatf("%s bank %0d b", name, k),
                              exp.port_b[k], rd_data.port_b[k]);
               end
            end
            OP_EXEC: begin
               apply_exec(row.mode, make_lanes(row.base, row.step), exp);
               check_pair(name, exp, rd_data);
            end
            OP_WRITE: apply_write(row.mask);
            default:  pulse_reset();
         endcase
      end

      $display("Done with %0d value errors", errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+include
logic/ntt_bank_pkg.sv
logic/dual_port_ram.sv
logic/read_addr_router.sv
logic/writeback_addr_delay.sv
logic/write_port_ctrl.sv
logic/ntt_bank_top.sv
testbench/tb_ntt_bank.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ntt_bank -f verilog.f -o tb_ntt_bank_sim

./obj_dir/tb_ntt_bank_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
   exit 1
fi
if ! grep -q "Regression passed" sim.log; then
   exit 1
fi
exit 0
